/* verilog/ising_pkg.sv */
// Ising problem types
package ising_pkg;

    // precision of one coupling or bias entry
    localparam int BITJ = 4;

    // energy accumulator width, wide enough for any row sum
    localparam int ENERGY_BIT = 32;

    // width of the unsigned bias scale
    localparam int SCALING_BIT = 4;

    // spin encoding
    // a bit of 1 stands for +1, a bit of 0 stands for -1
    // spin vectors are plain NUM_SPIN-bit words, sized by each module

    // one signed Jij or hi value, two's complement
    typedef logic signed [BITJ-1:0] coupling_t;

    // one signed energy value
    typedef logic signed [ENERGY_BIT-1:0] energy_t;

endpackage

/* verilog/macro_ctrl_pkg.sv */
// Macro control types
package macro_ctrl_pkg;

    // size of the flip mask table
    localparam int FLIP_ICON_DEPTH = 16;
    localparam int FLIP_ADDR_BIT = $clog2(FLIP_ICON_DEPTH);

    // run configuration, captured once per config pulse
    typedef struct packed {
        // accept only strictly lower energy
        logic en_comparison;
        // candidates equal the current spin
        logic flip_disable;
        // masks to walk, 0 up to FLIP_ICON_DEPTH
        logic [FLIP_ADDR_BIT:0] flip_count;
        // bias scale
        logic [ising_pkg::SCALING_BIT-1:0] hscaling;
    } run_cfg_t;

    // flip manager states
    typedef enum logic [2:0] {
        IDLE,
        BASELINE,
        FETCH,
        EVAL,
        DECIDE
    } fm_state_t;

endpackage

/* verilog/cfg_pulse_gen.sv */
// Config and start pulse generator
module cfg_pulse_gen (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic cfg_valid_i,
    input  logic cmpt_en_i,
    output logic cfg_pulse_o,
    output logic cmpt_pulse_o
);

    // bit 0 is config valid, bit 1 is compute enable
    logic [1:0] level;
    logic [1:0] level_q;

    assign level = {cmpt_en_i, cfg_valid_i};

    // host levels may stay high for many cycles, act on the rising edge only
    assign {cmpt_pulse_o, cfg_pulse_o} = level & ~level_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            level_q <= '0;
        end else begin
            level_q <= level;
        end
    end

endmodule

/* verilog/weight_fetch.sv */
// Weight memory read sequencer
module weight_fetch #(
    parameter int NUM_SPIN = 16,
    parameter int PARALLELISM = 4,
    localparam int GROUPS = NUM_SPIN / PARALLELISM,
    localparam int GROUP_AW = (GROUPS > 1) ? $clog2(GROUPS) : 1
) (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic start_i,
    output logic weight_ren_o,
    output logic [GROUP_AW-1:0] weight_raddr_o,
    output logic beat_valid_o,
    output logic [GROUP_AW-1:0] beat_group_o
);

    logic busy_q;
    logic [GROUP_AW-1:0] group_q;

    // one read per cycle while busy
    assign weight_ren_o = busy_q;
    assign weight_raddr_o = group_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            group_q <= '0;
            beat_valid_o <= 1'b0;
            beat_group_o <= '0;
        end else begin
            // memory answers one cycle after the read
            beat_valid_o <= busy_q;
            beat_group_o <= group_q;
            if (start_i) begin
                busy_q <= 1'b1;
                group_q <= '0;
            end else if (busy_q) begin
                if (group_q == GROUP_AW'(GROUPS - 1)) begin
                    busy_q <= 1'b0;
                    group_q <= '0;
                end else begin
                    group_q <= group_q + 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/energy_monitor.sv */
// Ising energy monitor
module energy_monitor #(
    parameter int NUM_SPIN = 16,
    parameter int PARALLELISM = 4,
    localparam int GROUPS = NUM_SPIN / PARALLELISM,
    localparam int GROUP_AW = (GROUPS > 1) ? $clog2(GROUPS) : 1
) (
    input  logic clk_i,
    input  logic arst_n_i,
    // candidate spin handshake
    input  logic cand_valid_i,
    output logic cand_ready_o,
    input  logic [NUM_SPIN-1:0] cand_spin_i,
    // weight beats
    output logic fetch_start_o,
    input  logic beat_valid_i,
    input  logic [GROUP_AW-1:0] beat_group_i,
    input  logic [PARALLELISM*NUM_SPIN*ising_pkg::BITJ-1:0] weight_rdata_i,
    input  logic [NUM_SPIN*ising_pkg::BITJ-1:0] hbias_i,
    input  logic [ising_pkg::SCALING_BIT-1:0] hscaling_i,
    // result strobe
    output logic energy_valid_o,
    output ising_pkg::energy_t energy_o
);
    import ising_pkg::*;

    logic accept;
    logic last_beat;
    logic busy_q;
    logic done_q;
    logic [NUM_SPIN-1:0] spin_q;
    energy_t acc_q;
    energy_t beat_sum;

    assign cand_ready_o = ~busy_q;
    assign accept = cand_valid_i & cand_ready_o;

    // fetch starts in the acceptance cycle
    assign fetch_start_o = accept;
    assign last_beat = beat_valid_i & (beat_group_i == GROUP_AW'(GROUPS - 1));

    assign energy_valid_o = done_q;
    assign energy_o = acc_q;

    // contribution of the PARALLELISM rows in the current beat
    always_comb begin
        energy_t row_sum;
        coupling_t j_val;
        coupling_t h_val;
        int row;
        beat_sum = '0;
        for (int k = 0; k < PARALLELISM; k++) begin
            row = int'(beat_group_i) * PARALLELISM + k;
            row_sum = '0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                j_val = weight_rdata_i[(k * NUM_SPIN + j) * BITJ +: BITJ];
                // sj is +1 or -1
                if (spin_q[j]) begin
                    row_sum = row_sum + j_val;
                end else begin
                    row_sum = row_sum - j_val;
                end
            end
            h_val = hbias_i[row * BITJ +: BITJ];
            row_sum = row_sum + h_val * $signed({1'b0, hscaling_i});
            // weight the row by si
            if (spin_q[row]) begin
                beat_sum = beat_sum + row_sum;
            end else begin
                beat_sum = beat_sum - row_sum;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= last_beat;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (last_beat) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            spin_q <= cand_spin_i;
            acc_q <= '0;
        end else if (beat_valid_i) begin
            acc_q <= acc_q + beat_sum;
        end
    end

endmodule

/* verilog/flip_manager.sv */
// Flip manager
module flip_manager #(
    parameter int NUM_SPIN = 16
) (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic cfg_pulse_i,
    input  logic cmpt_pulse_i,
    input  logic [NUM_SPIN-1:0] spin_init_i,
    input  macro_ctrl_pkg::run_cfg_t run_cfg_i,
    // flip mask memory
    output logic flip_ren_o,
    output logic [macro_ctrl_pkg::FLIP_ADDR_BIT-1:0] flip_raddr_o,
    input  logic [NUM_SPIN-1:0] flip_rdata_i,
    // candidate to the energy monitor
    output logic cand_valid_o,
    input  logic cand_ready_i,
    output logic [NUM_SPIN-1:0] cand_spin_o,
    input  logic energy_valid_i,
    input  ising_pkg::energy_t energy_i,
    // results
    output logic cmpt_idle_o,
    output logic energy_update_o,
    output ising_pkg::energy_t energy_o,
    output logic [NUM_SPIN-1:0] spin_o
);
    import ising_pkg::*;
    import macro_ctrl_pkg::*;

    fm_state_t state_q;
    logic [FLIP_ADDR_BIT:0] addr_q;
    logic mask_vld_q;
    logic base_q;
    logic accept;
    logic [NUM_SPIN-1:0] spin_q;
    logic [NUM_SPIN-1:0] cand_spin_q;
    energy_t cand_energy_q;

    assign cmpt_idle_o = (state_q == IDLE);
    assign flip_ren_o = (state_q == FETCH);
    assign flip_raddr_o = addr_q[FLIP_ADDR_BIT-1:0];
    assign cand_spin_o = cand_spin_q;

    // baseline always taken, otherwise strict improvement when comparing
    assign accept = base_q | ~run_cfg_i.en_comparison | (cand_energy_q < energy_o);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            addr_q <= '0;
            mask_vld_q <= 1'b0;
            base_q <= 1'b0;
            cand_valid_o <= 1'b0;
            energy_update_o <= 1'b0;
            energy_o <= '0;
            spin_o <= '0;
        end else begin
            mask_vld_q <= flip_ren_o;
            energy_update_o <= 1'b0;
            if (cand_valid_o && cand_ready_i) begin
                cand_valid_o <= 1'b0;
            end
            case (state_q)
                IDLE: begin
                    if (cmpt_pulse_i) begin
                        cand_valid_o <= 1'b1;
                        addr_q <= '0;
                        base_q <= 1'b1;
                        state_q <= BASELINE;
                    end
                end
                BASELINE: begin
                    if (energy_valid_i) begin
                        state_q <= DECIDE;
                    end
                end
                FETCH: begin
                    state_q <= EVAL;
                end
                EVAL: begin
                    // mask is on the read port this cycle
                    if (mask_vld_q) begin
                        cand_valid_o <= 1'b1;
                        addr_q <= addr_q + 1'b1;
                    end
                    if (energy_valid_i) begin
                        state_q <= DECIDE;
                    end
                end
                DECIDE: begin
                    base_q <= 1'b0;
                    if (accept) begin
                        energy_update_o <= 1'b1;
                        energy_o <= cand_energy_q;
                        spin_o <= cand_spin_q;
                    end
                    if (addr_q == run_cfg_i.flip_count) begin
                        state_q <= IDLE;
                    end else begin
                        state_q <= FETCH;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // spin state and candidate payload
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && cfg_pulse_i) begin
            spin_q <= spin_init_i;
        end else if (state_q == DECIDE && accept) begin
            spin_q <= cand_spin_q;
        end
        if (state_q == IDLE && cmpt_pulse_i) begin
            cand_spin_q <= spin_q;
        end else if (state_q == EVAL && mask_vld_q) begin
            cand_spin_q <= run_cfg_i.flip_disable ? spin_q : spin_q ^ flip_rdata_i;
        end
        if (energy_valid_i) begin
            cand_energy_q <= energy_i;
        end
    end

endmodule

/* verilog/digital_macro.sv */
// Digital compute macro
module digital_macro #(
    parameter int NUM_SPIN = 16,
    parameter int PARALLELISM = 4,
    localparam int GROUPS = NUM_SPIN / PARALLELISM,
    localparam int GROUP_AW = (GROUPS > 1) ? $clog2(GROUPS) : 1
) (
    input  logic clk_i,
    input  logic arst_n_i,
    // configuration and start
    input  logic cfg_valid_i,
    input  logic cmpt_en_i,
    input  macro_ctrl_pkg::run_cfg_t run_cfg_i,
    input  logic [NUM_SPIN-1:0] spin_init_i,
    // weight memory
    output logic weight_ren_o,
    output logic [GROUP_AW-1:0] weight_raddr_o,
    input  logic [PARALLELISM*NUM_SPIN*ising_pkg::BITJ-1:0] weight_rdata_i,
    input  logic [NUM_SPIN*ising_pkg::BITJ-1:0] hbias_i,
    // flip memory
    output logic flip_ren_o,
    output logic [macro_ctrl_pkg::FLIP_ADDR_BIT-1:0] flip_raddr_o,
    input  logic [NUM_SPIN-1:0] flip_rdata_i,
    // results
    output logic cmpt_idle_o,
    output logic energy_update_o,
    output ising_pkg::energy_t energy_o,
    output logic [NUM_SPIN-1:0] spin_o
);
    import ising_pkg::*;
    import macro_ctrl_pkg::*;

    logic cfg_pulse;
    logic cmpt_pulse;
    run_cfg_t cfg_q;
    logic cand_valid;
    logic cand_ready;
    logic [NUM_SPIN-1:0] cand_spin;
    logic energy_valid;
    energy_t energy;
    logic fetch_start;
    logic beat_valid;
    logic [GROUP_AW-1:0] beat_group;

    // run configuration, only taken between computations
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q <= '0;
        end else if (cfg_pulse && cmpt_idle_o) begin
            cfg_q <= run_cfg_i;
        end
    end

    cfg_pulse_gen u_cfg_pulse_gen (
        .clk_i        (clk_i       ),
        .arst_n_i     (arst_n_i    ),
        .cfg_valid_i  (cfg_valid_i ),
        .cmpt_en_i    (cmpt_en_i   ),
        .cfg_pulse_o  (cfg_pulse   ),
        .cmpt_pulse_o (cmpt_pulse  )
    );

    flip_manager #(
        .NUM_SPIN (NUM_SPIN)
    ) u_flip_manager (
        .clk_i           (clk_i          ),
        .arst_n_i        (arst_n_i       ),
        .cfg_pulse_i     (cfg_pulse      ),
        .cmpt_pulse_i    (cmpt_pulse     ),
        .spin_init_i     (spin_init_i    ),
        .run_cfg_i       (cfg_q          ),
        .flip_ren_o      (flip_ren_o     ),
        .flip_raddr_o    (flip_raddr_o   ),
        .flip_rdata_i    (flip_rdata_i   ),
        .cand_valid_o    (cand_valid     ),
        .cand_ready_i    (cand_ready     ),
        .cand_spin_o     (cand_spin      ),
        .energy_valid_i  (energy_valid   ),
        .energy_i        (energy         ),
        .cmpt_idle_o     (cmpt_idle_o    ),
        .energy_update_o (energy_update_o),
        .energy_o        (energy_o       ),
        .spin_o          (spin_o         )
    );

    energy_monitor #(
        .NUM_SPIN    (NUM_SPIN   ),
        .PARALLELISM (PARALLELISM)
    ) u_energy_monitor (
        .clk_i          (clk_i          ),
        .arst_n_i       (arst_n_i       ),
        .cand_valid_i   (cand_valid     ),
        .cand_ready_o   (cand_ready     ),
        .cand_spin_i    (cand_spin      ),
        .fetch_start_o  (fetch_start    ),
        .beat_valid_i   (beat_valid     ),
        .beat_group_i   (beat_group     ),
        .weight_rdata_i (weight_rdata_i ),
        .hbias_i        (hbias_i        ),
        .hscaling_i     (cfg_q.hscaling ),
        .energy_valid_o (energy_valid   ),
        .energy_o       (energy         )
    );

    weight_fetch #(
        .NUM_SPIN    (NUM_SPIN   ),
        .PARALLELISM (PARALLELISM)
    ) u_weight_fetch (
        .clk_i          (clk_i         ),
        .arst_n_i       (arst_n_i      ),
        .start_i        (fetch_start   ),
        .weight_ren_o   (weight_ren_o  ),
        .weight_raddr_o (weight_raddr_o),
        .beat_valid_o   (beat_valid    ),
        .beat_group_o   (beat_group    )
    );

endmodule

/* test/tb_ref_model.svh */
// Ising reference model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

    localparam logic [31:0] SEED = 32'h2d7f_29ea;

    logic [31:0] rng_state;
    logic signed [BITJ-1:0] j_mem [NUM_SPIN][NUM_SPIN];
    logic signed [BITJ-1:0] h_mem [NUM_SPIN];
    logic [NUM_SPIN-1:0] mask_mem [FLIP_ICON_DEPTH];
    logic [NUM_SPIN-1:0] spin_start;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // couplings, biases, masks and start spins for one test
    task automatic fill_images(input int unsigned seed_offset);
        logic [31:0] r;
        rng_state = SEED + seed_offset;
        for (int i = 0; i < NUM_SPIN; i++) begin
            for (int j = 0; j < NUM_SPIN; j++) begin
                r = next_rand();
                j_mem[i][j] = r[BITJ-1:0];
            end
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            r = next_rand();
            h_mem[i] = r[BITJ-1:0];
        end
        // sparse masks, a few spins each
        for (int m = 0; m < FLIP_ICON_DEPTH; m++) begin
            r = next_rand();
            mask_mem[m] = r[15:0] & r[31:16];
        end
        r = next_rand();
        spin_start = r[NUM_SPIN-1:0];
    endtask

    // row group g as it sits on the weight bus
    function automatic logic [PARALLELISM*NUM_SPIN*BITJ-1:0] pack_group(input int g);
        logic [PARALLELISM*NUM_SPIN*BITJ-1:0] w;
        for (int k = 0; k < PARALLELISM; k++) begin
            for (int j = 0; j < NUM_SPIN; j++) begin
                w[(k * NUM_SPIN + j) * BITJ +: BITJ] = j_mem[g * PARALLELISM + k][j];
            end
        end
        return w;
    endfunction

    function automatic logic [NUM_SPIN*BITJ-1:0] pack_bias();
        logic [NUM_SPIN*BITJ-1:0] b;
        for (int i = 0; i < NUM_SPIN; i++) begin
            b[i * BITJ +: BITJ] = h_mem[i];
        end
        return b;
    endfunction

    // E = sum_i si * (sum_j Jij*sj + hi*hscale), bit 1 is +1
    function automatic int ising_energy(input logic [NUM_SPIN-1:0] s, input int hscale);
        int e;
        int row;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            row = int'(h_mem[i]) * hscale;
            for (int j = 0; j < NUM_SPIN; j++) begin
                row = s[j] ? row + int'(j_mem[i][j]) : row - int'(j_mem[i][j]);
            end
            e = s[i] ? e + row : e - row;
        end
        return e;
    endfunction

    // greedy search replay, baseline always taken
    task automatic replay_search(input bit en_cmp, input bit flip_dis, input int count,
                                 input int hscale, output int best_e,
                                 output logic [NUM_SPIN-1:0] best_s, output int updates);
        logic [NUM_SPIN-1:0] cand;
        int e;
        best_s = spin_start;
        best_e = ising_energy(spin_start, hscale);
        updates = 1;
        for (int m = 0; m < count; m++) begin
            cand = flip_dis ? best_s : best_s ^ mask_mem[m];
            e = ising_energy(cand, hscale);
            if (!en_cmp || e < best_e) begin
                best_e = e;
                best_s = cand;
                updates++;
            end
        end
    endtask

`endif

/* test/tb_digital_macro.sv */
// Digital macro testbench
module tb_digital_macro;
    timeunit 1ns;
    timeprecision 1ps;
    import ising_pkg::*;
    import macro_ctrl_pkg::*;

    localparam int NUM_SPIN = 16;
    localparam int PARALLELISM = 4;
    localparam int GROUPS = NUM_SPIN / PARALLELISM;
    localparam int GROUP_AW = (GROUPS > 1) ? $clog2(GROUPS) : 1;
    localparam int IDLE_TIMEOUT = 2000;

    typedef struct {
        string name;
        bit en_comparison;
        bit flip_disable;
        logic [FLIP_ADDR_BIT:0] flip_count;
        logic [SCALING_BIT-1:0] hscaling;
        int unsigned seed_offset;
        bit expect_baseline;
    } test_row_t;

    `include "tb_ref_model.svh"

    logic clk_i = 1'b0;
    logic arst_n_i;
    logic cfg_valid_i;
    logic cmpt_en_i;
    run_cfg_t run_cfg_i;
    logic [NUM_SPIN-1:0] spin_init_i;
    logic [PARALLELISM*NUM_SPIN*BITJ-1:0] weight_rdata_i;
    logic [NUM_SPIN*BITJ-1:0] hbias_i;
    logic [NUM_SPIN-1:0] flip_rdata_i;
    logic weight_ren_o;
    logic [GROUP_AW-1:0] weight_raddr_o;
    logic flip_ren_o;
    logic [FLIP_ADDR_BIT-1:0] flip_raddr_o;
    logic cmpt_idle_o;
    logic energy_update_o;
    energy_t energy_o;
    logic [NUM_SPIN-1:0] spin_o;

    logic w_pend_q;
    logic [GROUP_AW-1:0] w_addr_q;
    logic f_pend_q;
    logic [FLIP_ADDR_BIT-1:0] f_addr_q;
    int update_count;
    int error_count;
    int test_errors;
    int tests_failed;
    test_row_t tests[$];

    digital_macro #(
        .NUM_SPIN    (NUM_SPIN   ),
        .PARALLELISM (PARALLELISM)
    ) DUT (
        .clk_i           (clk_i          ),
        .arst_n_i        (arst_n_i       ),
        .cfg_valid_i     (cfg_valid_i    ),
        .cmpt_en_i       (cmpt_en_i      ),
        .run_cfg_i       (run_cfg_i      ),
        .spin_init_i     (spin_init_i    ),
        .weight_ren_o    (weight_ren_o   ),
        .weight_raddr_o  (weight_raddr_o ),
        .weight_rdata_i  (weight_rdata_i ),
        .hbias_i         (hbias_i        ),
        .flip_ren_o      (flip_ren_o     ),
        .flip_raddr_o    (flip_raddr_o   ),
        .flip_rdata_i    (flip_rdata_i   ),
        .cmpt_idle_o     (cmpt_idle_o    ),
        .energy_update_o (energy_update_o),
        .energy_o        (energy_o       ),
        .spin_o          (spin_o         )
    );

    always #20 clk_i = ~clk_i;

    // memories take the read at the rising edge and answer in the next cycle
    always @(posedge clk_i) begin
        w_pend_q <= weight_ren_o;
        w_addr_q <= weight_raddr_o;
        f_pend_q <= flip_ren_o;
        f_addr_q <= flip_raddr_o;
    end

    always @(negedge clk_i) begin
        if (w_pend_q) begin
            weight_rdata_i <= pack_group(int'(w_addr_q));
        end
        if (f_pend_q) begin
            flip_rdata_i <= mask_mem[f_addr_q];
        end
        if (energy_update_o) begin
            update_count++;
        end
    end

    task automatic check_value(input string test, input string what,
                               input longint expected, input longint actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s expected %0d actual %0d", test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic add_test(input string name, input bit en_cmp, input bit flip_dis,
                            input int count, input int hscale, input int unsigned offset,
                            input bit expect_base);
        test_row_t r;
        r.name = name;
        r.en_comparison = en_cmp;
        r.flip_disable = flip_dis;
        r.flip_count = count[FLIP_ADDR_BIT:0];
        r.hscaling = hscale[SCALING_BIT-1:0];
        r.seed_offset = offset;
        r.expect_baseline = expect_base;
        tests.push_back(r);
    endtask

    task automatic wait_idle(output bit timed_out);
        timed_out = 1'b1;
        for (int cycles = 0; cycles < IDLE_TIMEOUT; cycles++) begin
            @(negedge clk_i);
            if (cmpt_idle_o) begin
                timed_out = 1'b0;
                break;
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-18s %s", name, (test_errors == 0) ? "passed" : "failed");
        error_count += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
    endtask

    task automatic run_test(input test_row_t t, output bit aborted);
        int exp_e;
        int exp_n;
        logic [NUM_SPIN-1:0] exp_s;
        logic [NUM_SPIN-1:0] xor_all;
        bit timed_out;
        aborted = 1'b0;
        test_errors = 0;
        fill_images(t.seed_offset);
        replay_search(t.en_comparison, t.flip_disable, int'(t.flip_count),
                      int'(t.hscaling), exp_e, exp_s, exp_n);
        @(negedge clk_i);
        hbias_i = pack_bias();
        spin_init_i = spin_start;
        run_cfg_i.en_comparison = t.en_comparison;
        run_cfg_i.flip_disable = t.flip_disable;
        run_cfg_i.flip_count = t.flip_count;
        run_cfg_i.hscaling = t.hscaling;
        update_count = 0;
        // levels held for several cycles must act once
        cfg_valid_i = 1'b1;
        @(negedge clk_i);
        // a reload while the level stays high would take these
        spin_init_i = ~spin_start;
        run_cfg_i.en_comparison = ~t.en_comparison;
        run_cfg_i.hscaling = ~t.hscaling;
        repeat (5) @(negedge clk_i);
        cfg_valid_i = 1'b0;
        @(negedge clk_i);
        cmpt_en_i = 1'b1;
        @(negedge clk_i);
        check_value(t.name, "cmpt_idle_o after start", 0, cmpt_idle_o);
        @(negedge clk_i);
        cmpt_en_i = 1'b0;
        @(negedge clk_i);
        // second start edge lands mid run and stays high past the end
        cmpt_en_i = 1'b1;
        wait_idle(timed_out);
        if (timed_out) begin
            $display("test %s: computation did not finish within %0d cycles",
                     t.name, IDLE_TIMEOUT);
            test_errors++;
            aborted = 1'b1;
        end else begin
            // a start level still high would leave idle again here
            @(negedge clk_i);
            check_value(t.name, "cmpt_idle_o after run", 1, cmpt_idle_o);
            check_value(t.name, "energy_o", exp_e, energy_o);
            check_value(t.name, "spin_o", exp_s, spin_o);
            check_value(t.name, "update count", exp_n, update_count);
            if (t.expect_baseline) begin
                check_value(t.name, "baseline spin", spin_start, spin_o);
                check_value(t.name, "baseline energy",
                            ising_energy(spin_start, int'(t.hscaling)), energy_o);
                check_value(t.name, "baseline updates", 1, update_count);
            end
            if (!t.en_comparison) begin
                xor_all = spin_start;
                for (int m = 0; m < int'(t.flip_count); m++) begin
                    if (!t.flip_disable) begin
                        xor_all = xor_all ^ mask_mem[m];
                    end
                end
                check_value(t.name, "all-accept spin", xor_all, spin_o);
                check_value(t.name, "all-accept updates", t.flip_count + 1, update_count);
            end
        end
        cmpt_en_i = 1'b0;
        finish_test(t.name);
    endtask

    initial begin
        bit aborted;
        arst_n_i = 1'b0;
        cfg_valid_i = 1'b0;
        cmpt_en_i = 1'b0;
        run_cfg_i = '0;
        spin_init_i = '0;
        weight_rdata_i = '0;
        hbias_i = '0;
        flip_rdata_i = '0;
        update_count = 0;
        error_count = 0;
        tests_failed = 0;
        aborted = 1'b0;

        add_test("baseline_only", 1'b1, 1'b0, 0, 3, 0, 1'b1);
        add_test("cmp_off_all", 1'b0, 1'b0, 16, 2, 1, 1'b0);
        add_test("cmp_off_few", 1'b0, 1'b0, 5, 0, 2, 1'b0);
        add_test("greedy_full", 1'b1, 1'b0, 16, 1, 3, 1'b0);
        add_test("greedy_part", 1'b1, 1'b0, 9, 7, 4, 1'b0);
        add_test("flip_disabled", 1'b1, 1'b1, 8, 4, 5, 1'b1);
        add_test("greedy_hscale_max", 1'b1, 1'b0, 12, 15, 6, 1'b0);

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        test_errors = 0;
        check_value("reset", "cmpt_idle_o", 1, cmpt_idle_o);
        check_value("reset", "energy_update_o", 0, energy_update_o);
        check_value("reset", "weight_ren_o", 0, weight_ren_o);
        check_value("reset", "flip_ren_o", 0, flip_ren_o);
        check_value("reset", "energy_o", 0, energy_o);
        check_value("reset", "spin_o", 0, spin_o);
        finish_test("reset");

        for (int i = 0; i < tests.size() && !aborted; i++) begin
            run_test(tests[i], aborted);
        end

        $display("%0d tests run, %0d failed, %0d errors",
                 tests.size() + 1, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+test
verilog/ising_pkg.sv
verilog/macro_ctrl_pkg.sv
verilog/cfg_pulse_gen.sv
verilog/weight_fetch.sv
verilog/energy_monitor.sv
verilog/flip_manager.sv
verilog/digital_macro.sv
test/tb_digital_macro.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing -Wno-fatal -j 0
TOP   := tb_digital_macro
FLIST := src.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
